// File: list.f
verilog/vexec_pkg.sv
verilog/elementwise_alu.sv
verilog/matmul_tile.sv
verilog/result_stage.sv
verilog/vexec_ctrl.sv
verilog/vector_exec_unit.sv
dv/tb_vector_exec_unit.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the vector unit testbench with Verilator.
# Exit status is 0 only when the log holds the pass line.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
TOP=tb_vector_exec_unit

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f list.f --top-module "$TOP" -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/V"$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "TEST PASSED" "$LOG"; then
    exit 0
fi
exit 1

// File: dv/tb_vector_exec_unit.sv
// Directed testbench for the vector unit; assumes NUM_ELEMS of 8 and the fixed 1 and 4 cycle latencies
`timescale 1ns/1ps
`default_nettype none

module tb_vector_exec_unit
    import vexec_pkg::*;
;
    localparam int NUM_ELEMS  = 8;
    localparam int DONE_WAIT  = 10;
    // About 40 operations of at most 8 cycles each, with wide margin
    localparam int MAX_CYCLES = 2000;

    typedef elem_t [NUM_ELEMS-1:0] vec_t;

    logic    clk_i = 1'b0;
    logic    rst_ni;
    logic    start_i;
    funct7_t funct7_i;
    vec_t    vec_a_i;
    vec_t    vec_b_i;
    vec_t    vec_c_i;
    logic    done_o;
    vec_t    result_o;

    int value_errs = 0;
    int proto_errs = 0;
    int cycle_cnt  = 0;

    vector_exec_unit #(
        .NUM_ELEMS (NUM_ELEMS)
    ) u_dut (
        .clk_i    (clk_i),
        .rst_ni   (rst_ni),
        .start_i  (start_i),
        .funct7_i (funct7_i),
        .vec_a_i  (vec_a_i),
        .vec_b_i  (vec_b_i),
        .vec_c_i  (vec_c_i),
        .done_o   (done_o),
        .result_o (result_o)
    );

    always #10 clk_i = ~clk_i;

    always @(posedge clk_i) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("Timeout: the run went past %0d cycles", MAX_CYCLES);
            $display("TEST FAILED");
            $finish;
        end
    end

    // ====================
    // Reference model
    // ====================
    function automatic vec_t lane_model(input funct7_t f, input vec_t a, input vec_t b,
                                        input vec_t c);
        vec_t r;
        int   i;
        for (i = 0; i < NUM_ELEMS; i++) begin
            case (f)
                FUNCT7_VMAC: r[i] = a[i] * b[i] + c[i];
                FUNCT7_VADD: r[i] = a[i] + b[i];
                FUNCT7_VSUB: r[i] = a[i] - b[i];
                FUNCT7_VMUL: r[i] = a[i] * b[i];
                default:     r[i] = '0;
            endcase
        end
        return r;
    endfunction

    // C = A x B on row-major 2x2 tiles, wrapping at 32 bits
    function automatic vec_t mmul_model(input vec_t a, input vec_t b);
        vec_t  r;
        elem_t sum;
        int    i;
        int    j;
        int    k;
        r = '0;
        for (i = 0; i < 2; i++) begin
            for (j = 0; j < 2; j++) begin
                sum = '0;
                for (k = 0; k < 2; k++) begin
                    sum = sum + a[i*2 + k] * b[k*2 + j];
                end
                r[i*2 + j] = sum;
            end
        end
        return r;
    endfunction

    function automatic vec_t rand_vec(input bit near_max);
        vec_t v;
        int   i;
        for (i = 0; i < NUM_ELEMS; i++) begin
            if (near_max) begin
                v[i] = 32'hFFFF_FFFF - ($urandom % 256);
            end else begin
                v[i] = $urandom;
            end
        end
        return v;
    endfunction

    // ====================
    // Drivers and checks
    // ====================
    task automatic drive_op(input funct7_t f, input vec_t a, input vec_t b, input vec_t c);
        start_i  <= 1'b1;
        funct7_i <= f;
        vec_a_i  <= a;
        vec_b_i  <= b;
        vec_c_i  <= c;
    endtask

    // Cycle count starts at the accepting edge
    task automatic wait_done(output int lat, output bit seen);
        lat  = 0;
        seen = 1'b0;
        while (!seen && lat < DONE_WAIT) begin
            @(negedge clk_i);
            lat++;
            seen = done_o;
        end
    endtask

    task automatic run_op(input funct7_t f, input vec_t a, input vec_t b, input vec_t c,
                          input int exp_lat, input vec_t exp_res, input string name);
        int lat;
        bit seen;
        @(posedge clk_i);
        drive_op(f, a, b, c);
        @(posedge clk_i);
        start_i <= 1'b0;
        wait_done(lat, seen);
        assert (seen) else begin
            proto_errs++;
            $display("No done pulse arrived for %s within %0d cycles", name, DONE_WAIT);
        end
        if (seen) begin
            assert (lat == exp_lat) else begin
                proto_errs++;
                $display("Done for %s came after %0d cycles instead of %0d", name, lat, exp_lat);
            end
            assert (result_o === exp_res) else begin
                value_errs++;
                $display("ERR @%0t: %s result %h, expected %h", $time, name, result_o, exp_res);
            end
            @(negedge clk_i);
            assert (!done_o) else begin
                proto_errs++;
                $display("Done for %s stayed high for more than one cycle", name);
            end
        end
    endtask

    // ====================
    // Tests
    // ====================
    task automatic reset_test();
        @(negedge clk_i);
        assert (done_o === 1'b0 && result_o === '0) else begin
            value_errs++;
            $display("ERR @%0t: after reset done %b result %h", $time, done_o, result_o);
        end
    endtask

    task automatic lane_ops_test();
        funct7_t codes [4];
        vec_t    a;
        vec_t    b;
        vec_t    c;
        int      op;
        int      n;
        codes[0] = FUNCT7_VADD;
        codes[1] = FUNCT7_VSUB;
        codes[2] = FUNCT7_VMUL;
        codes[3] = FUNCT7_VMAC;
        for (op = 0; op < 4; op++) begin
            for (n = 0; n < 6; n++) begin
                a = rand_vec(n[0]);
                b = rand_vec(n[1]);
                c = rand_vec(n[0]);
                run_op(codes[op], a, b, c, 1, lane_model(codes[op], a, b, c), "lane op");
            end
        end
    endtask

    task automatic mmul_test();
        vec_t a;
        vec_t b;
        int   n;
        for (n = 0; n < 5; n++) begin
            a = rand_vec(n == 4);
            b = rand_vec(n == 4);
            run_op(FUNCT7_VMMUL, a, b, rand_vec(1'b0), 4, mmul_model(a, b), "VMMUL");
        end
    endtask

    // VADD start lands while the matmul is in K1
    task automatic busy_start_test();
        vec_t a;
        vec_t b;
        vec_t exp_res;
        int   pulses;
        int   n;
        a       = rand_vec(1'b0);
        b       = rand_vec(1'b0);
        exp_res = mmul_model(a, b);
        pulses  = 0;
        @(posedge clk_i);
        drive_op(FUNCT7_VMMUL, a, b, '0);
        @(posedge clk_i);
        start_i <= 1'b0;
        @(posedge clk_i);
        drive_op(FUNCT7_VADD, rand_vec(1'b0), rand_vec(1'b0), '0);
        @(posedge clk_i);
        start_i <= 1'b0;
        for (n = 0; n < 6; n++) begin
            @(negedge clk_i);
            if (done_o) begin
                pulses++;
                assert (n == 1) else begin
                    proto_errs++;
                    $display("Done for the matmul came at the wrong cycle");
                end
            end
        end
        assert (pulses == 1) else begin
            proto_errs++;
            $display("Expected one done pulse with a start dropped, saw %0d", pulses);
        end
        assert (result_o === exp_res) else begin
            value_errs++;
            $display("ERR @%0t: busy start result %h, expected %h", $time, result_o, exp_res);
        end
    endtask

    task automatic unknown_code_test();
        run_op(7'h00, rand_vec(1'b0), rand_vec(1'b0), rand_vec(1'b0), 1, '0, "code 0x00");
        run_op(7'h05, rand_vec(1'b0), rand_vec(1'b0), rand_vec(1'b0), 1, '0, "code 0x05");
        run_op(7'h7F, rand_vec(1'b1), rand_vec(1'b1), rand_vec(1'b1), 1, '0, "code 0x7f");
    endtask

    // Each op is driven at the edge that opens the previous done cycle
    task automatic back_to_back_test();
        funct7_t fs [4];
        vec_t    as [4];
        vec_t    bs [4];
        vec_t    cs [4];
        vec_t    exp_res;
        int      lat;
        int      n;
        fs[0] = FUNCT7_VADD;
        fs[1] = FUNCT7_VMMUL;
        fs[2] = FUNCT7_VSUB;
        fs[3] = FUNCT7_VMAC;
        for (n = 0; n < 4; n++) begin
            as[n] = rand_vec(1'b0);
            bs[n] = rand_vec(1'b0);
            cs[n] = rand_vec(1'b0);
        end
        @(posedge clk_i);
        drive_op(fs[0], as[0], bs[0], cs[0]);
        for (n = 0; n < 4; n++) begin
            lat = (fs[n] == FUNCT7_VMMUL) ? 4 : 1;
            if (fs[n] == FUNCT7_VMMUL) begin
                exp_res = mmul_model(as[n], bs[n]);
            end else begin
                exp_res = lane_model(fs[n], as[n], bs[n], cs[n]);
            end
            @(posedge clk_i);
            if (lat > 1) begin
                start_i <= 1'b0;
                repeat (lat - 1) begin
                    @(negedge clk_i);
                    assert (!done_o) else begin
                        proto_errs++;
                        $display("Early done pulse during chained op %0d", n);
                    end
                    @(posedge clk_i);
                end
            end
            if (n < 3) begin
                drive_op(fs[n+1], as[n+1], bs[n+1], cs[n+1]);
            end else begin
                start_i <= 1'b0;
            end
            @(negedge clk_i);
            assert (done_o) else begin
                proto_errs++;
                $display("No done pulse for chained op %0d", n);
            end
            assert (result_o === exp_res) else begin
                value_errs++;
                $display("ERR @%0t: chained op %0d result %h, expected %h", $time, n,
                         result_o, exp_res);
            end
        end
        @(negedge clk_i);
        assert (!done_o) else begin
            proto_errs++;
            $display("Extra done pulse after the chained ops");
        end
    endtask

    // ====================
    // Main sequence
    // ====================
    initial begin
        void'($urandom(32'hc513c894));
        rst_ni   <= 1'b0;
        start_i  <= 1'b0;
        funct7_i <= '0;
        vec_a_i  <= '0;
        vec_b_i  <= '0;
        vec_c_i  <= '0;
        repeat (3) @(posedge clk_i);
        rst_ni <= 1'b1;

        reset_test();
        lane_ops_test();
        mmul_test();
        busy_start_test();
        unknown_code_test();
        back_to_back_test();

        $display("Summary: %0d value errors, %0d protocol errors", value_errs, proto_errs);
        if (value_errs == 0 && proto_errs == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog/vector_exec_unit.sv
// Vector execution unit; NUM_ELEMS must be at least 4, starts while busy are dropped, no queue
`timescale 1ns/1ps
`default_nettype none

module vector_exec_unit
    import vexec_pkg::*;
#(
    parameter int NUM_ELEMS = 8
) (
    input  wire logic                    clk_i,
    input  wire logic                    rst_ni,

    // Operation request
    input  wire logic                    start_i,
    input  wire funct7_t                 funct7_i,

    // Operands, element 0 in the low word
    input  wire elem_t [NUM_ELEMS-1:0]   vec_a_i,
    input  wire elem_t [NUM_ELEMS-1:0]   vec_b_i,
    input  wire elem_t [NUM_ELEMS-1:0]   vec_c_i,

    // Completion
    output logic                         done_o,
    output elem_t [NUM_ELEMS-1:0]        result_o
);

    lane_op_t                lane_op;
    logic                    lane_capture;
    mm_cmd_t                 mm_cmd;
    elem_t [NUM_ELEMS-1:0]   lane_result;
    elem_t [MM_ELEMS-1:0]    tile_result;

    // ====================
    // Control
    // ====================
    vexec_ctrl u_ctrl (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .start_i        (start_i),
        .funct7_i       (funct7_i),
        .lane_op_o      (lane_op),
        .lane_capture_o (lane_capture),
        .mm_cmd_o       (mm_cmd),
        .done_o         (done_o)
    );

    // ====================
    // Datapath
    // ====================
    elementwise_alu #(
        .NUM_ELEMS (NUM_ELEMS)
    ) u_alu (
        .vec_a_i       (vec_a_i),
        .vec_b_i       (vec_b_i),
        .vec_c_i       (vec_c_i),
        .lane_op_i     (lane_op),
        .lane_result_o (lane_result)
    );

    matmul_tile #(
        .NUM_ELEMS (NUM_ELEMS)
    ) u_tile (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .vec_a_i       (vec_a_i),
        .vec_b_i       (vec_b_i),
        .mm_cmd_i      (mm_cmd),
        .tile_result_o (tile_result)
    );

    result_stage #(
        .NUM_ELEMS (NUM_ELEMS)
    ) u_result (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .lane_capture_i (lane_capture),
        .lane_result_i  (lane_result),
        .mm_cmd_i       (mm_cmd),
        .tile_result_i  (tile_result),
        .result_o       (result_o)
    );

endmodule

`default_nettype wire

// File: verilog/vexec_ctrl.sv
// Operation controller; one op in flight, single registered done pulse, unknown codes give zero
`timescale 1ns/1ps
`default_nettype none

module vexec_ctrl
    import vexec_pkg::*;
(
    input  wire logic     clk_i,
    input  wire logic     rst_ni,

    input  wire logic     start_i,
    input  wire funct7_t  funct7_i,

    output lane_op_t      lane_op_o,
    output logic          lane_capture_o,
    output mm_cmd_t       mm_cmd_o,
    output logic          done_o
);

    typedef enum logic [1:0] {
        CTRL_IDLE     = 2'd0,
        CTRL_MM_K0    = 2'd1,
        CTRL_MM_K1    = 2'd2,
        CTRL_MM_STORE = 2'd3
    } ctrl_state_e;

    ctrl_state_e state_q;
    ctrl_state_e state_d;
    lane_op_t    dec_op;
    logic        accept;
    logic        is_mmul;
    logic        done_q;

    // ====================
    // Decode and accept
    // ====================
    always_comb begin
        case (funct7_i)
            FUNCT7_VMAC: dec_op = LANE_MAC;
            FUNCT7_VADD: dec_op = LANE_ADD;
            FUNCT7_VSUB: dec_op = LANE_SUB;
            FUNCT7_VMUL: dec_op = LANE_MUL;
            default:     dec_op = LANE_NONE;
        endcase
    end

    // Only taken when nothing is in flight
    assign accept  = start_i && (state_q == CTRL_IDLE);
    assign is_mmul = (funct7_i == FUNCT7_VMMUL);

    // Unknown codes also capture here, with LANE_NONE giving zero
    assign lane_capture_o = accept && !is_mmul;
    assign lane_op_o      = accept ? dec_op : LANE_NONE;

    // ====================
    // Matmul sequencing
    // ====================
    always_comb begin
        state_d  = state_q;
        mm_cmd_o = '0;
        case (state_q)
            CTRL_IDLE: begin
                if (accept && is_mmul) begin
                    mm_cmd_o.load = 1'b1;
                    state_d       = CTRL_MM_K0;
                end
            end
            CTRL_MM_K0: begin
                // First k-step overwrites the accumulators
                mm_cmd_o.feed = 1'b1;
                mm_cmd_o.k    = 1'b0;
                state_d       = CTRL_MM_K1;
            end
            CTRL_MM_K1: begin
                mm_cmd_o.feed = 1'b1;
                mm_cmd_o.k    = 1'b1;
                state_d       = CTRL_MM_STORE;
            end
            CTRL_MM_STORE: begin
                mm_cmd_o.capture = 1'b1;
                state_d          = CTRL_IDLE;
            end
            default: begin
                state_d = CTRL_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= CTRL_IDLE;
            done_q  <= 1'b0;
        end else begin
            state_q <= state_d;
            // Pulse follows whichever capture happened this edge
            done_q  <= lane_capture_o || mm_cmd_o.capture;
        end
    end

    assign done_o = done_q;

endmodule

`default_nettype wire

// File: verilog/result_stage.sv
// Result register; holds until the next capture, matmul captures zero all elements above 3
`timescale 1ns/1ps
`default_nettype none

module result_stage
    import vexec_pkg::*;
#(
    parameter int NUM_ELEMS = 8
) (
    input  wire logic                   clk_i,
    input  wire logic                   rst_ni,

    input  wire logic                   lane_capture_i,
    input  wire elem_t [NUM_ELEMS-1:0]  lane_result_i,
    input  wire mm_cmd_t                mm_cmd_i,
    input  wire elem_t [MM_ELEMS-1:0]   tile_result_i,

    output elem_t [NUM_ELEMS-1:0]       result_o
);

    elem_t [NUM_ELEMS-1:0] mm_vec;

    // Tile product packed into the low elements
    always_comb begin
        mm_vec                 = '0;
        mm_vec[MM_ELEMS-1:0]   = tile_result_i;
    end

    // ====================
    // Capture register
    // ====================
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            result_o <= '0;
        end else if (lane_capture_i) begin
            result_o <= lane_result_i;
        end else if (mm_cmd_i.capture) begin
            result_o <= mm_vec;
        end
    end

endmodule

`default_nettype wire

// File: verilog/matmul_tile.sv
// 2x2 matmul tile; A and B come row-major from elements 0..3, result is the low 32 bits per cell
`timescale 1ns/1ps
`default_nettype none

module matmul_tile
    import vexec_pkg::*;
#(
    parameter int NUM_ELEMS = 8
) (
    input  wire logic                   clk_i,
    input  wire logic                   rst_ni,

    input  wire elem_t [NUM_ELEMS-1:0]  vec_a_i,
    input  wire elem_t [NUM_ELEMS-1:0]  vec_b_i,
    input  wire mm_cmd_t                mm_cmd_i,

    output elem_t [MM_ELEMS-1:0]        tile_result_o
);

    // Operand tiles, row-major
    elem_t [MM_ELEMS-1:0] a_q;
    elem_t [MM_ELEMS-1:0] b_q;

    // ====================
    // Operand load
    // ====================
    always_ff @(posedge clk_i) begin
        if (mm_cmd_i.load) begin
            a_q <= vec_a_i[MM_ELEMS-1:0];
            b_q <= vec_b_i[MM_ELEMS-1:0];
        end
    end

    // ====================
    // MAC array
    // ====================
    // Cell (r,c) sees A[r][k] from column k of A and B[k][c] from row k of B
    for (genvar r = 0; r < MM_DIM; r++) begin : g_row
        for (genvar c = 0; c < MM_DIM; c++) begin : g_col
            elem_t a_in;
            elem_t b_in;
            acc_t  prod;
            acc_t  acc_q;

            assign a_in = mm_cmd_i.k ? a_q[r*MM_DIM + 1] : a_q[r*MM_DIM];
            assign b_in = mm_cmd_i.k ? b_q[MM_DIM + c] : b_q[c];
            assign prod = acc_t'(a_in) * acc_t'(b_in);

            always_ff @(posedge clk_i or negedge rst_ni) begin
                if (!rst_ni) begin
                    acc_q <= '0;
                end else if (mm_cmd_i.feed) begin
                    // k=0 starts a fresh sum
                    if (mm_cmd_i.k) begin
                        acc_q <= acc_q + prod;
                    end else begin
                        acc_q <= prod;
                    end
                end
            end

            assign tile_result_o[r*MM_DIM + c] = acc_q[ELEM_W-1:0];
        end
    end

endmodule

`default_nettype wire

// File: verilog/elementwise_alu.sv
// Combinational lane ALU; all results wrap modulo 2^32, unsigned multiply keeps the low word
`timescale 1ns/1ps
`default_nettype none

module elementwise_alu
    import vexec_pkg::*;
#(
    parameter int NUM_ELEMS = 8
) (
    input  wire elem_t [NUM_ELEMS-1:0]  vec_a_i,
    input  wire elem_t [NUM_ELEMS-1:0]  vec_b_i,
    input  wire elem_t [NUM_ELEMS-1:0]  vec_c_i,
    input  wire lane_op_t               lane_op_i,

    output elem_t [NUM_ELEMS-1:0]       lane_result_o
);

    // ====================
    // Per-lane datapath
    // ====================
    for (genvar i = 0; i < NUM_ELEMS; i++) begin : g_lane
        acc_t  prod;
        elem_t prod_lo;
        elem_t res;

        // Full product, only the low word is architecturally visible
        assign prod    = acc_t'(vec_a_i[i]) * acc_t'(vec_b_i[i]);
        assign prod_lo = prod[ELEM_W-1:0];

        always_comb begin
            case (lane_op_i)
                LANE_MAC: res = prod_lo + vec_c_i[i];
                LANE_ADD: res = vec_a_i[i] + vec_b_i[i];
                LANE_SUB: res = vec_a_i[i] - vec_b_i[i];
                LANE_MUL: res = prod_lo;
                default:  res = '0;
            endcase
        end

        assign lane_result_o[i] = res;
    end

endmodule

`default_nettype wire

// File: verilog/vexec_pkg.sv
// Shared vector unit types; lane and tile widths are fixed at 32-bit elements and a 2x2 tile
`default_nettype none

package vexec_pkg;

    // ====================
    // Widths and types
    // ====================
    localparam int ELEM_W = 32;
    localparam int ACC_W  = 64;

    typedef logic [ELEM_W-1:0] elem_t;
    typedef logic [ACC_W-1:0]  acc_t;
    typedef logic [6:0]        funct7_t;

    // Matrix tile geometry
    localparam int MM_DIM   = 2;
    localparam int MM_ELEMS = MM_DIM * MM_DIM;

    // ====================
    // Function codes
    // ====================
    localparam funct7_t FUNCT7_VMAC  = 7'h01;
    localparam funct7_t FUNCT7_VADD  = 7'h02;
    localparam funct7_t FUNCT7_VSUB  = 7'h03;
    localparam funct7_t FUNCT7_VMUL  = 7'h04;
    localparam funct7_t FUNCT7_VMMUL = 7'h08;

    // Decoded element-wise operation
    typedef enum logic [2:0] {
        LANE_NONE = 3'd0,
        LANE_MAC  = 3'd1,
        LANE_ADD  = 3'd2,
        LANE_SUB  = 3'd3,
        LANE_MUL  = 3'd4
    } lane_op_t;

    // Matmul command, one strobe set per cycle
    typedef struct packed {
        logic load;
        logic feed;
        logic k;
        logic capture;
    } mm_cmd_t;

endpackage

`default_nettype wire
